//--- hw/utim64_pkg.sv
package utim64_pkg;

	// Data widths
	typedef logic [31:0] tim_word_t;
	typedef logic [63:0] tim_count_t;
	typedef logic [4:0] bus_addr_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [3:0] irq_vec_t;
	// Timer A low nibble, timer B high nibble
	typedef logic [7:0] flag_vec_t;

	// Compare channels per timer
	localparam int CHANNELS = 4;

	// Per-timer register offsets
	// Config bit 0 count enable, bits 4..1 compare enables
	localparam reg_addr_t REG_CONFIG = 4'd0;
	localparam reg_addr_t REG_COUNT_LO = 4'd1;
	localparam reg_addr_t REG_COUNT_HI = 4'd2;
	// Channel k low word at 4+2k, high word at 5+2k
	localparam reg_addr_t REG_CMP_BASE = 4'd4;
	// Last offset decoded into a timer window
	localparam reg_addr_t REG_LAST = 4'hE;

	// Peripheral address map
	localparam bus_addr_t BASE_TIM_A = 5'h00;
	localparam bus_addr_t BASE_TIM_B = 5'h10;
	localparam bus_addr_t ADDR_FLAGS = 5'h1F;

	// Request on the outside bus
	typedef struct packed {
		logic rw;
		bus_addr_t addr;
		tim_word_t data;
	} bus_req_t;

	// Request as one timer sees it
	typedef struct packed {
		logic rw;
		reg_addr_t addr;
		tim_word_t data;
	} tim_req_t;

	typedef enum logic {SEL_IDLE, SEL_RD_WAIT} sel_state_t;
	typedef enum logic [1:0] {IRQ_IDLE, IRQ_PENDING, IRQ_ACKED} irq_state_t;
	typedef enum logic [1:0] {SEL_TIM_A, SEL_TIM_B, SEL_FLAGS} mod_sel_t;

endpackage

//--- hw/utim64_tick_sync.sv
`timescale 1ns/1ps

module utim64_tick_sync (
	input logic iCLOCK,
	input logic inRESET,
	input logic timer_clock,
	output logic tick
);

	// Two sync stages plus previous sample
	logic sync_1;
	logic sync_2;
	logic sync_prev;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_1 <= timer_clock;
			sync_2 <= sync_1;
			sync_prev <= sync_2;
		end
	end

	// One-cycle strobe per rising edge
	assign tick = sync_2 && !sync_prev;

endmodule

//--- hw/utim64.sv
`timescale 1ns/1ps

module utim64 (
	input logic iCLOCK,
	input logic inRESET,
	input logic tick,
	input logic req_valid,
	input utim64_pkg::tim_req_t req,
	output logic rd_valid,
	output utim64_pkg::tim_word_t rd_data,
	output utim64_pkg::irq_vec_t irq
);

	logic [4:0] cfg;
	logic cnt_en;
	utim64_pkg::irq_vec_t cmp_en;
	utim64_pkg::tim_count_t count;
	utim64_pkg::tim_count_t cmp [utim64_pkg::CHANNELS];
	logic wr;
	logic rd;
	logic inc;
	logic inc_q;
	utim64_pkg::tim_word_t rd_mux;

	// Config fields
	assign cnt_en = cfg[0];
	assign cmp_en = cfg[4:1];

	assign wr = req_valid && req.rw;
	assign rd = req_valid && !req.rw;
	assign inc = tick && cnt_en;

	// Config register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg <= '0;
		end else if (wr && req.addr == utim64_pkg::REG_CONFIG) begin
			cfg <= req.data[4:0];
		end
	end

	// Counter
	// Loading a half wins over a tick in the same cycle
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
			inc_q <= 1'b0;
		end else begin
			inc_q <= 1'b0;
			if (wr && req.addr == utim64_pkg::REG_COUNT_LO) begin
				count[31:0] <= req.data;
			end else if (wr && req.addr == utim64_pkg::REG_COUNT_HI) begin
				count[63:32] <= req.data;
			end else if (inc) begin
				count <= count + 64'd1;
				// Marks a freshly incremented count
				inc_q <= 1'b1;
			end
		end
	end

	// Compare values, two words per channel
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int k = 0; k < utim64_pkg::CHANNELS; k++) begin
				cmp[k] <= '0;
			end
		end else if (wr) begin
			for (int k = 0; k < utim64_pkg::CHANNELS; k++) begin
				if (req.addr == utim64_pkg::reg_addr_t'(utim64_pkg::REG_CMP_BASE + 2 * k)) begin
					cmp[k][31:0] <= req.data;
				end
				if (req.addr == utim64_pkg::reg_addr_t'(utim64_pkg::REG_CMP_BASE + 2 * k + 1)) begin
					cmp[k][63:32] <= req.data;
				end
			end
		end
	end

	// Match pulses
	// Only checked the cycle after an increment
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq <= '0;
		end else begin
			for (int k = 0; k < utim64_pkg::CHANNELS; k++) begin
				irq[k] <= inc_q && cnt_en && cmp_en[k] && (count == cmp[k]);
			end
		end
	end

	// Read select
	always_comb begin
		rd_mux = '0;
		case (req.addr)
			utim64_pkg::REG_CONFIG: rd_mux = {27'd0, cfg};
			utim64_pkg::REG_COUNT_LO: rd_mux = count[31:0];
			utim64_pkg::REG_COUNT_HI: rd_mux = count[63:32];
			default: begin
				// Compare words, anything else stays zero
				for (int k = 0; k < utim64_pkg::CHANNELS; k++) begin
					if (req.addr == utim64_pkg::reg_addr_t'(utim64_pkg::REG_CMP_BASE + 2 * k)) begin
						rd_mux = cmp[k][31:0];
					end
					if (req.addr ==
						utim64_pkg::reg_addr_t'(utim64_pkg::REG_CMP_BASE + 2 * k + 1)) begin
						rd_mux = cmp[k][63:32];
					end
				end
			end
		endcase
	end

	// Read response one cycle after the request
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rd) begin
			rd_data <= rd_mux;
		end
	end

endmodule

//--- hw/utim64_irq_flags.sv
`timescale 1ns/1ps

module utim64_irq_flags (
	input logic iCLOCK,
	input logic inRESET,
	input utim64_pkg::irq_vec_t irq_a,
	input utim64_pkg::irq_vec_t irq_b,
	input logic flags_read,
	input logic irq_ack,
	output logic irq_valid,
	output logic flags_rd_valid,
	output utim64_pkg::flag_vec_t flags_rd_data
);

	utim64_pkg::irq_state_t state;
	utim64_pkg::flag_vec_t flags;
	utim64_pkg::flag_vec_t pulses;

	// Timer B in the high nibble
	assign pulses = {irq_b, irq_a};

	// Sticky flags and interrupt FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= utim64_pkg::IRQ_IDLE;
			flags <= '0;
		end else begin
			// Pulses accumulate every cycle
			flags <= flags | pulses;
			case (state)
				utim64_pkg::IRQ_IDLE: begin
					if (|pulses) begin
						state <= utim64_pkg::IRQ_PENDING;
					end
				end
				utim64_pkg::IRQ_PENDING: begin
					if (irq_ack) begin
						state <= utim64_pkg::IRQ_ACKED;
					end
				end
				utim64_pkg::IRQ_ACKED: begin
					// Read clears, keeping only this cycle's pulses
					if (flags_read) begin
						state <= utim64_pkg::IRQ_IDLE;
						flags <= pulses;
					end
				end
				default: state <= utim64_pkg::IRQ_IDLE;
			endcase
		end
	end

	// Line held for the whole pending state
	assign irq_valid = (state == utim64_pkg::IRQ_PENDING);

	// Registered read response
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flags_rd_valid <= 1'b0;
		end else begin
			flags_rd_valid <= flags_read;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (flags_read) begin
			flags_rd_data <= flags;
		end
	end

endmodule

//--- hw/dps_utim64.sv
`timescale 1ns/1ps

module dps_utim64 (
	input logic iCLOCK,
	input logic inRESET,
	input logic timer_clock,
	input logic req_valid,
	input utim64_pkg::bus_req_t req,
	input logic irq_ack,
	output logic req_busy,
	output logic rsp_valid,
	output utim64_pkg::tim_word_t rsp_data,
	output logic irq_valid
);

	utim64_pkg::sel_state_t state;
	utim64_pkg::mod_sel_t sel;
	utim64_pkg::tim_req_t tim_req;
	logic accept;
	logic hit_a;
	logic hit_b;
	logic hit_flags;
	logic a_tick;
	logic b_tick;
	logic a_rd_valid;
	logic b_rd_valid;
	utim64_pkg::tim_word_t a_rd_data;
	utim64_pkg::tim_word_t b_rd_data;
	utim64_pkg::irq_vec_t a_irq;
	utim64_pkg::irq_vec_t b_irq;
	logic flags_rd_valid;
	utim64_pkg::flag_vec_t flags_rd_data;

	// Accept only while idle
	assign accept = req_valid && (state == utim64_pkg::SEL_IDLE);

	// Address decode, offset 0xF of each window falls outside
	assign hit_a = (req.addr[4] == utim64_pkg::BASE_TIM_A[4]) &&
		(req.addr[3:0] <= utim64_pkg::REG_LAST);
	assign hit_b = (req.addr[4] == utim64_pkg::BASE_TIM_B[4]) &&
		(req.addr[3:0] <= utim64_pkg::REG_LAST);
	assign hit_flags = (req.addr == utim64_pkg::ADDR_FLAGS);

	// Both timers see the full 4-bit offset
	assign tim_req = '{rw: req.rw, addr: req.addr[3:0], data: req.data};

	// Read select FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= utim64_pkg::SEL_IDLE;
			sel <= utim64_pkg::SEL_TIM_A;
		end else begin
			case (state)
				utim64_pkg::SEL_IDLE: begin
					if (accept && !req.rw) begin
						state <= utim64_pkg::SEL_RD_WAIT;
						// 0x0F lands on timer A, which stays silent
						if (hit_b) begin
							sel <= utim64_pkg::SEL_TIM_B;
						end else if (hit_flags) begin
							sel <= utim64_pkg::SEL_FLAGS;
						end else begin
							sel <= utim64_pkg::SEL_TIM_A;
						end
					end
				end
				default: state <= utim64_pkg::SEL_IDLE;
			endcase
		end
	end

	// Busy and response share the single wait cycle
	assign req_busy = (state == utim64_pkg::SEL_RD_WAIT);
	assign rsp_valid = (state == utim64_pkg::SEL_RD_WAIT);

	utim64_tick_sync tick_a (.iCLOCK, .inRESET, .timer_clock, .tick(a_tick));
	utim64_tick_sync tick_b (.iCLOCK, .inRESET, .timer_clock, .tick(b_tick));

	utim64 tim_a (
		.iCLOCK, .inRESET, .tick(a_tick), .req_valid(accept && hit_a), .req(tim_req),
		.rd_valid(a_rd_valid), .rd_data(a_rd_data), .irq(a_irq)
	);

	utim64 tim_b (
		.iCLOCK, .inRESET, .tick(b_tick), .req_valid(accept && hit_b), .req(tim_req),
		.rd_valid(b_rd_valid), .rd_data(b_rd_data), .irq(b_irq)
	);

	utim64_irq_flags flags (
		.iCLOCK, .inRESET, .irq_a(a_irq), .irq_b(b_irq),
		.flags_read(accept && !req.rw && hit_flags), .irq_ack, .irq_valid,
		.flags_rd_valid, .flags_rd_data
	);

	// Response mux, zero when the selected source did not answer
	always_comb begin
		case (sel)
			utim64_pkg::SEL_TIM_A: rsp_data = a_rd_valid ? a_rd_data : '0;
			utim64_pkg::SEL_TIM_B: rsp_data = b_rd_valid ? b_rd_data : '0;
			utim64_pkg::SEL_FLAGS: rsp_data = flags_rd_valid ? {24'd0, flags_rd_data} : '0;
			default: rsp_data = '0;
		endcase
	end

endmodule

//--- verification/dps_utim64_asserts.sv
`timescale 1ns/1ps

module dps_utim64_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic req_valid,
	input utim64_pkg::bus_req_t req,
	input logic req_busy,
	input logic rsp_valid,
	input logic irq_valid
);

	logic rd_accept;

	// Read taken on this edge
	assign rd_accept = req_valid && !req_busy && !req.rw;

	// Response lasts a single cycle
	rsp_single: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rsp_valid |=> !rsp_valid)
		else $error("rsp_valid held for more than one cycle");

	// Accepted read answered on the next cycle
	rsp_after_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_accept |=> rsp_valid)
		else $error("accepted read not answered on the next cycle");

	// no response without a read just before
	rsp_has_read: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rsp_valid |-> $past(rd_accept))
		else $error("rsp_valid without an accepted read one cycle earlier");

	// Quiet outputs in reset
	quiet_in_reset: assert property (@(posedge iCLOCK) !inRESET |-> !req_busy && !irq_valid)
		else $error("req_busy or irq_valid high during reset");

endmodule

bind dps_utim64 dps_utim64_asserts asserts (
	.iCLOCK, .inRESET, .req_valid, .req, .req_busy, .rsp_valid, .irq_valid
);

//--- verification/tb_dps_utim64.sv
`timescale 1ns/1ps

module tb_dps_utim64;

	// About 25 timer edges of 16 cycles per counting test, plus margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int COUNT_EDGES = 20;

	logic iCLOCK;
	logic inRESET;
	logic timer_clock;
	logic req_valid;
	utim64_pkg::bus_req_t req;
	logic irq_ack;
	logic req_busy;
	logic rsp_valid;
	utim64_pkg::tim_word_t rsp_data;
	logic irq_valid;

	// Shadow of writable registers by bus address
	utim64_pkg::tim_word_t shadow [32];
	// Pending read results for the compare process
	utim64_pkg::tim_word_t exp_q [$];
	utim64_pkg::tim_word_t got_q [$];
	string name_q [$];
	logic [31:0] rng_state = 32'd94;
	int errors = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycles = 0;

	dps_utim64 dut (
		.iCLOCK, .inRESET, .timer_clock, .req_valid, .req, .irq_ack,
		.req_busy, .rsp_valid, .rsp_data, .irq_valid
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Slow timer clock, 16 system cycles per period
	initial begin
		timer_clock = 1'b0;
		forever #800 timer_clock = ~timer_clock;
	end

	always @(posedge iCLOCK) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// Expected read data from the register map
	function automatic utim64_pkg::tim_word_t ref_read(utim64_pkg::bus_addr_t addr);
		logic [3:0] off;
		off = addr[3:0];
		if (off == 4'd0) begin
			return {27'd0, shadow[addr][4:0]};
		end else if (off == 4'd1 || off == 4'd2 || (off >= 4'd4 && off <= 4'd11)) begin
			return shadow[addr];
		end
		// Register 3, 12 to 15 and the flag address read zero here
		return '0;
	endfunction

	task automatic check_value(string name, utim64_pkg::tim_word_t got,
		utim64_pkg::tim_word_t exp);
		if (got !== exp) begin
			$display("error %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// Compare results once they are settled
	always @(negedge iCLOCK) begin
		while (got_q.size() > 0) begin
			check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
	end

	task automatic wait_idle();
		while (req_busy) begin
			@(posedge iCLOCK);
			#10;
		end
	endtask

	task automatic bus_write(utim64_pkg::bus_addr_t addr, utim64_pkg::tim_word_t data);
		wait_idle();
		req_valid = 1'b1;
		req = '{rw: 1'b1, addr: addr, data: data};
		shadow[addr] = data;
		@(posedge iCLOCK);
		#10;
		req_valid = 1'b0;
	endtask

	task automatic bus_read(utim64_pkg::bus_addr_t addr, output utim64_pkg::tim_word_t data);
		wait_idle();
		req_valid = 1'b1;
		req = '{rw: 1'b0, addr: addr, data: 32'd0};
		@(posedge iCLOCK);
		#10;
		req_valid = 1'b0;
		if (!rsp_valid) begin
			$display("read of 0x%02h got no rsp_valid on the cycle after acceptance", addr);
			errors++;
		end
		data = rsp_data;
	endtask

	task automatic read_check(utim64_pkg::bus_addr_t addr, utim64_pkg::tim_word_t exp);
		utim64_pkg::tim_word_t got;
		bus_read(addr, got);
		name_q.push_back($sformatf("rsp_data@0x%02h", addr));
		got_q.push_back(got);
		exp_q.push_back(exp);
	endtask

	task automatic read_all();
		for (int a = 0; a < 32; a++) begin
			read_check(utim64_pkg::bus_addr_t'(a), ref_read(utim64_pkg::bus_addr_t'(a)));
		end
	endtask

	// Count from start to start+3 with one compare channel armed
	task automatic run_compare(utim64_pkg::bus_addr_t base, int ch);
		utim64_pkg::tim_count_t start;
		utim64_pkg::tim_count_t target;
		utim64_pkg::bus_addr_t cmp_lo;
		int n;
		start = {xorshift32(), xorshift32()};
		target = start + 64'd3;
		cmp_lo = base + 5'(4 + 2 * ch);
		bus_write(base + 5'd1, start[31:0]);
		bus_write(base + 5'd2, start[63:32]);
		bus_write(cmp_lo, target[31:0]);
		bus_write(cmp_lo + 5'd1, target[63:32]);
		bus_write(base, 32'(1 | (2 << ch)));
		n = 0;
		while (!irq_valid && n < 200) begin
			@(posedge iCLOCK);
			#10;
			n++;
		end
		if (!irq_valid) begin
			$display("irq_valid never rose for compare channel %0d", ch);
			errors++;
		end
		bus_write(base, 32'd0);
	endtask

	task automatic ack_and_clear(utim64_pkg::tim_word_t flags_exp);
		irq_ack = 1'b1;
		@(posedge iCLOCK);
		#10;
		irq_ack = 1'b0;
		check_value("irq_valid", 32'(irq_valid), 32'd0);
		read_check(5'h1F, flags_exp);
		read_check(5'h1F, 32'd0);
	endtask

	task automatic end_test(string name);
		@(negedge iCLOCK);
		#1;
		if (errors == test_errors) begin
			$display("test %s: passed", name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", name, errors - test_errors);
			tests_failed++;
		end
		test_errors = errors;
		// Back onto the drive point
		@(posedge iCLOCK);
		#10;
	endtask

	initial begin
		utim64_pkg::tim_count_t loaded;
		utim64_pkg::tim_count_t cnt;
		utim64_pkg::tim_word_t lo_w;
		utim64_pkg::tim_word_t hi_w;
		int edges;
		inRESET = 1'b0;
		req_valid = 1'b0;
		req = '0;
		irq_ack = 1'b0;
		for (int a = 0; a < 32; a++) begin
			shadow[a] = '0;
		end
		repeat (3) @(posedge iCLOCK);
		#10;
		inRESET = 1'b1;

		check_value("req_busy", 32'(req_busy), 32'd0);
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);
		check_value("irq_valid", 32'(irq_valid), 32'd0);
		read_all();
		end_test("reset_state");

		// Everything but the config words, holes included
		for (int a = 0; a < 32; a++) begin
			if (a % 16 != 0) begin
				bus_write(utim64_pkg::bus_addr_t'(a), xorshift32());
			end
		end
		read_all();
		end_test("register_readback");

		loaded = {xorshift32(), xorshift32()};
		bus_write(5'h01, loaded[31:0]);
		bus_write(5'h02, loaded[63:32]);
		// Enable well clear of a timer edge so no stale tick lands
		@(posedge timer_clock);
		repeat (4) @(posedge iCLOCK);
		#10;
		bus_write(5'h00, 32'd1);
		edges = 0;
		while (edges < COUNT_EDGES) begin
			@(posedge timer_clock);
			edges++;
		end
		repeat (4) @(posedge iCLOCK);
		#10;
		bus_write(5'h00, 32'd0);
		bus_read(5'h01, lo_w);
		bus_read(5'h02, hi_w);
		cnt = {hi_w, lo_w};
		check_value("count_a_in_range",
			32'(cnt >= loaded + 64'(edges - 1) && cnt <= loaded + 64'(edges)), 32'd1);
		// Timer B stayed disabled
		read_check(5'h10, ref_read(5'h10));
		read_check(5'h11, ref_read(5'h11));
		read_check(5'h12, ref_read(5'h12));
		end_test("counting");

		run_compare(5'h00, 2);
		read_check(5'h1F, 32'h04);
		check_value("irq_valid", 32'(irq_valid), 32'd1);
		end_test("compare_interrupt");

		ack_and_clear(32'h04);
		run_compare(5'h10, 0);
		read_check(5'h1F, 32'h10);
		ack_and_clear(32'h10);
		end_test("ack_and_clear");

		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- dps_utim64.f
hw/utim64_pkg.sv
hw/utim64_tick_sync.sv
hw/utim64.sv
hw/utim64_irq_flags.sv
hw/dps_utim64.sv
verification/dps_utim64_asserts.sv
verification/tb_dps_utim64.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_dps_utim64
FILELIST ?= dps_utim64.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
